// File: verilog.f
logic/hdc_pkg.sv
logic/axil_ctrl_regs.sv
logic/hv_generator.sv
logic/hd_encoder_core.sv
logic/bundle_combiner.sv
logic/hdc_accel_top.sv
tests/hdc_accel_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       := hdc_accel_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/hdc_accel_tb.sv
module hdc_accel_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hdc_pkg::*;

    localparam int DIM       = DEF_DIM;
    localparam int ITEM_AW   = DEF_ITEM_AW;
    localparam int CNT_W     = DEF_CNT_W;
    // generator words per item
    localparam int WPI       = DIM / RNG_WORD_W;
    localparam int TIMEOUT   = 200;
    localparam int GEN_ITEMS = 12;

    logic                          AXIS_ACLK = 1'b0;
    logic                          S_AXI_ARESETN;
    logic [AXIL_ADDR_W-1:0]        S_AXI_AWADDR;
    logic                          S_AXI_AWVALID;
    logic                          S_AXI_AWREADY;
    logic [AXIL_DATA_W-1:0]        S_AXI_WDATA;
    logic                          S_AXI_WVALID;
    logic                          S_AXI_WREADY;
    logic                          S_AXI_BREADY;
    logic [1:0]                    S_AXI_BRESP;
    logic                          S_AXI_BVALID;
    logic [AXIL_ADDR_W-1:0]        S_AXI_ARADDR;
    logic                          S_AXI_ARVALID;
    logic                          S_AXI_ARREADY;
    logic                          S_AXI_RREADY;
    logic [AXIL_DATA_W-1:0]        S_AXI_RDATA;
    logic [1:0]                    S_AXI_RRESP;
    logic                          S_AXI_RVALID;
    logic [LANE_W*NUM_LANES-1:0]   S_AXIS_TDATA;
    logic                          S_AXIS_TVALID;
    logic                          S_AXIS_TLAST;
    logic                          S_AXIS_TREADY;
    logic [DIM-1:0]                M_AXIS_TDATA;
    logic                          M_AXIS_TVALID;
    logic                          M_AXIS_TLAST;
    logic                          M_AXIS_TREADY;

    // edge counter, read on falling edges only
    int                            cyc = 0;
    // cycle of the TLAST handshake
    int                            hs_cyc;
    logic [DIM-1:0]                item_tab [2**ITEM_AW];
    // item indices of the current frame, per lane
    int                            fa [$];
    int                            fb [$];
    logic [AXIL_DATA_W-1:0]        rd;

    hdc_accel_top #(.DIM(DIM), .ITEM_AW(ITEM_AW), .CNT_W(CNT_W)) u_hdc_accel_top (.*);

    always #20 AXIS_ACLK = ~AXIS_ACLK;

    always @(posedge AXIS_ACLK) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [DIM-1:0] got, input logic [DIM-1:0] exp,
                            input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0d ns: %s, got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [RNG_WORD_W-1:0] xorshift32(input logic [RNG_WORD_W-1:0] s);
        logic [RNG_WORD_W-1:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // item k holds words k*WPI onward, first word lowest
    task automatic build_items(input int n);
        logic [RNG_WORD_W-1:0] s;
        s = RNG_SEED;
        for (int k = 0; k < n; k++) begin
            for (int w = 0; w < WPI; w++) begin
                s = xorshift32(s);
                item_tab[k][w*RNG_WORD_W +: RNG_WORD_W] = s;
            end
        end
    endtask

    // ones over both lanes against half the lookups, tie gives 0
    function automatic logic [DIM-1:0] majority_vec();
        logic [DIM-1:0] v;
        int             sum;
        for (int d = 0; d < DIM; d++) begin
            sum = 0;
            for (int b = 0; b < fa.size(); b++) begin
                sum += int'(item_tab[fa[b]][d]) + int'(item_tab[fb[b]][d]);
            end
            v[d] = (sum > fa.size());
        end
        return v;
    endfunction

    // random upper bits, only the low bits pick the item
    function automatic logic [LANE_W-1:0] lane_word(input int idx);
        logic [LANE_W-1:0] w;
        w = LANE_W'($urandom);
        w[ITEM_AW-1:0] = ITEM_AW'(idx);
        return w;
    endfunction

    // ----------------------------------------
    // AXI-Lite tasks, entered on a falling edge
    // ----------------------------------------
    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data);
        int   t;
        logic aw_left;
        logic w_left;
        logic take_aw;
        logic take_w;
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WVALID  = 1'b1;
        S_AXI_BREADY  = 1'b1;
        aw_left = 1'b1;
        w_left  = 1'b1;
        t = 0;
        // ready depends on state only, so it holds through the next edge
        while (aw_left || w_left) begin
            take_aw = aw_left && S_AXI_AWREADY;
            take_w  = w_left && S_AXI_WREADY;
            @(negedge AXIS_ACLK);
            if (take_aw) begin
                aw_left       = 1'b0;
                S_AXI_AWVALID = 1'b0;
            end
            if (take_w) begin
                w_left       = 1'b0;
                S_AXI_WVALID = 1'b0;
            end
            t++;
            if (t > TIMEOUT) abort_run("write address or data was never accepted");
        end
        t = 0;
        while (!S_AXI_BVALID) begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > TIMEOUT) abort_run("write response never arrived");
        end
        check_eq(S_AXI_BRESP, RESP_OKAY, "write response code");
        @(negedge AXIS_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data);
        int t;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        S_AXI_RREADY  = 1'b1;
        t = 0;
        while (!S_AXI_ARREADY) begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > TIMEOUT) abort_run("read address was never accepted");
        end
        @(negedge AXIS_ACLK);
        S_AXI_ARVALID = 1'b0;
        t = 0;
        while (!S_AXI_RVALID) begin
            @(negedge AXIS_ACLK);
            t++;
            if (t > TIMEOUT) abort_run("read data never arrived");
        end
        data = S_AXI_RDATA;
        check_eq(S_AXI_RRESP, RESP_OKAY, "read response code");
        @(negedge AXIS_ACLK);
        S_AXI_RREADY = 1'b0;
    endtask

    // count first, then gen with run, then poll gen low
    task automatic run_generation(input int n);
        ctrl_word_u cw;
        int         t;
        logic [AXIL_DATA_W-1:0] v;
        cw = '0;
        cw.count.item_count = 10'(n);
        axil_write(REG_COUNT_ADDR, cw);
        axil_read(REG_COUNT_ADDR, v);
        check_eq(v, n, "item count readback");
        cw = '0;
        cw.mode.run = 1'b1;
        cw.mode.gen = 1'b1;
        axil_write(REG_MODE_ADDR, cw);
        t = 0;
        axil_read(REG_MODE_ADDR, v);
        while (v[0]) begin
            t++;
            if (t > TIMEOUT) abort_run("gen bit never cleared after generation");
            axil_read(REG_MODE_ADDR, v);
        end
        check_eq(v[1], 1'b1, "run bit after generation");
    endtask

    // ----------------------------------------
    // stream tasks
    // ----------------------------------------
    task automatic make_frame(input int n_items);
        int len;
        fa.delete();
        fb.delete();
        len = $urandom_range(1, 20);
        repeat (len) begin
            fa.push_back($urandom_range(0, n_items - 1));
            fb.push_back($urandom_range(0, n_items - 1));
        end
    endtask

    task automatic send_frame();
        int t;
        for (int b = 0; b < fa.size(); b++) begin
            // occasional idle cycle between beats
            if ($urandom_range(0, 3) == 0) begin
                S_AXIS_TVALID = 1'b0;
                @(negedge AXIS_ACLK);
            end
            S_AXIS_TDATA  = {lane_word(fb[b]), lane_word(fa[b])};
            S_AXIS_TLAST  = (b == fa.size() - 1);
            S_AXIS_TVALID = 1'b1;
            t = 0;
            while (!S_AXIS_TREADY) begin
                @(negedge AXIS_ACLK);
                t++;
                if (t > TIMEOUT) abort_run("input beat was never accepted");
            end
            check_eq(M_AXIS_TVALID, 1'b0, "output before frame end");
            hs_cyc = cyc;
            @(negedge AXIS_ACLK);
        end
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
    endtask

    task automatic recv_output(input logic [DIM-1:0] exp, input bit stall);
        int             t;
        bit             seen;
        bit             taken;
        logic [DIM-1:0] held;
        t     = 0;
        seen  = 1'b0;
        taken = 1'b0;
        held  = '0;
        while (!taken) begin
            // frame closed, no input until the result leaves
            check_eq(S_AXIS_TREADY, 1'b0, "S_AXIS_TREADY while output pending");
            M_AXIS_TREADY = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
            if (M_AXIS_TVALID) begin
                if (!seen) begin
                    seen = 1'b1;
                    held = M_AXIS_TDATA;
                    check_eq(cyc - hs_cyc, 3, "TVALID cycles after TLAST handshake");
                end
                check_eq(M_AXIS_TDATA, held, "TDATA change under stall");
                check_eq(M_AXIS_TLAST, 1'b1, "TLAST on output beat");
                taken = M_AXIS_TREADY;
            end
            @(negedge AXIS_ACLK);
            t++;
            if (t > TIMEOUT) abort_run("output beat never taken");
        end
        M_AXIS_TREADY = 1'b0;
        check_eq(held, exp, "output sign vector");
        check_eq(M_AXIS_TVALID, 1'b0, "extra output beat");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'he51e1bb8));
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        S_AXIS_TDATA  = '0;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        M_AXIS_TREADY = 1'b0;
        repeat (3) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge AXIS_ACLK);
        build_items(GEN_ITEMS);

        // idle outputs after reset
        check_eq(S_AXI_BVALID, 1'b0, "BVALID after reset");
        check_eq(S_AXI_RVALID, 1'b0, "RVALID after reset");
        check_eq(M_AXIS_TVALID, 1'b0, "M_AXIS_TVALID after reset");
        check_eq(S_AXIS_TREADY, 1'b0, "S_AXIS_TREADY after reset");
        axil_read(REG_MODE_ADDR, rd);
        check_eq(rd, 0, "mode after reset");
        axil_read(REG_COUNT_ADDR, rd);
        check_eq(rd, 0, "count after reset");
        axil_read(32'h8, rd);
        check_eq(rd, 0, "unmapped read at 0x8");
        axil_read(32'h40, rd);
        check_eq(rd, 0, "unmapped read at 0x40");

        // first item set, 12 items
        run_generation(GEN_ITEMS);

        // unmapped reads while both registers hold nonzero values
        axil_read(32'h8, rd);
        check_eq(rd, 0, "unmapped read at 0x8 with registers set");
        axil_read(32'hC, rd);
        check_eq(rd, 0, "unmapped read at 0xC with registers set");

        // random frames, sink always ready
        repeat (25) begin
            make_frame(GEN_ITEMS);
            send_frame();
            recv_output(majority_vec(), 1'b0);
        end
        // random frames, sink stalls
        repeat (25) begin
            make_frame(GEN_ITEMS);
            send_frame();
            recv_output(majority_vec(), 1'b1);
        end

        // one beat, same item both lanes, gives the item back
        for (int k = 0; k < GEN_ITEMS; k++) begin
            fa.delete();
            fb.delete();
            fa.push_back(k);
            fb.push_back(k);
            send_frame();
            recv_output(item_tab[k], 1'b0);
        end

        // regenerate 5 items, same seed so same table
        run_generation(5);
        repeat (15) begin
            make_frame(5);
            send_frame();
            recv_output(majority_vec(), 1'b1);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: logic/hdc_accel_top.sv
module hdc_accel_top #(
    parameter int DIM     = hdc_pkg::DEF_DIM,
    parameter int ITEM_AW = hdc_pkg::DEF_ITEM_AW,
    parameter int CNT_W   = hdc_pkg::DEF_CNT_W
) (
    input  logic                                       AXIS_ACLK,
    input  logic                                       S_AXI_ARESETN,

    // AXI-Lite slave
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0]            S_AXI_AWADDR,
    input  logic                                       S_AXI_AWVALID,
    output logic                                       S_AXI_AWREADY,
    input  logic [hdc_pkg::AXIL_DATA_W-1:0]            S_AXI_WDATA,
    input  logic                                       S_AXI_WVALID,
    output logic                                       S_AXI_WREADY,
    input  logic                                       S_AXI_BREADY,
    output logic [1:0]                                 S_AXI_BRESP,
    output logic                                       S_AXI_BVALID,
    input  logic [hdc_pkg::AXIL_ADDR_W-1:0]            S_AXI_ARADDR,
    input  logic                                       S_AXI_ARVALID,
    output logic                                       S_AXI_ARREADY,
    input  logic                                       S_AXI_RREADY,
    output logic [hdc_pkg::AXIL_DATA_W-1:0]            S_AXI_RDATA,
    output logic [1:0]                                 S_AXI_RRESP,
    output logic                                       S_AXI_RVALID,

    // instruction stream in
    input  logic [hdc_pkg::LANE_W*hdc_pkg::NUM_LANES-1:0] S_AXIS_TDATA,
    input  logic                                       S_AXIS_TVALID,
    input  logic                                       S_AXIS_TLAST,
    output logic                                       S_AXIS_TREADY,

    // sign vector out
    output logic [DIM-1:0]                             M_AXIS_TDATA,
    output logic                                       M_AXIS_TVALID,
    output logic                                       M_AXIS_TLAST,
    input  logic                                       M_AXIS_TREADY
);
    import hdc_pkg::*;

    logic                      gen;
    logic                      run;
    logic [9:0]                item_count;
    logic                      gen_done;
    logic                      item_wr_en;
    logic [ITEM_AW-1:0]        item_wr_addr;
    logic [DIM-1:0]            item_wr_data;
    logic                      beat_accept;
    logic [DIM-1:0][CNT_W-1:0] counts_a;
    logic [DIM-1:0][CNT_W-1:0] counts_b;
    logic                      frame_done_a;

    assign beat_accept = S_AXIS_TVALID && S_AXIS_TREADY;

    axil_ctrl_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .gen_done      (gen_done),
        .gen           (gen),
        .run           (run),
        .item_count    (item_count)
    );

    hv_generator #(.DIM(DIM), .ITEM_AW(ITEM_AW)) u_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .item_wr_en    (item_wr_en),
        .item_wr_addr  (item_wr_addr),
        .item_wr_data  (item_wr_data),
        .gen_done      (gen_done)
    );

    // ----------------------------------------
    // one core per lane
    // ----------------------------------------
    hd_encoder_core #(.DIM(DIM), .ITEM_AW(ITEM_AW), .CNT_W(CNT_W)) u_core_a (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .item_wr_en    (item_wr_en),
        .item_wr_addr  (item_wr_addr),
        .item_wr_data  (item_wr_data),
        .beat_accept   (beat_accept),
        .beat_last     (S_AXIS_TLAST),
        .lane          (S_AXIS_TDATA[LANE_W-1:0]),
        .counts        (counts_a),
        .frame_done    (frame_done_a)
    );

    hd_encoder_core #(.DIM(DIM), .ITEM_AW(ITEM_AW), .CNT_W(CNT_W)) u_core_b (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .item_wr_en    (item_wr_en),
        .item_wr_addr  (item_wr_addr),
        .item_wr_data  (item_wr_data),
        .beat_accept   (beat_accept),
        .beat_last     (S_AXIS_TLAST),
        .lane          (S_AXIS_TDATA[2*LANE_W-1:LANE_W]),
        .counts        (counts_b),
        .frame_done    ()
    );

    // both cores run in lockstep, lane a marks the frame end
    bundle_combiner #(.DIM(DIM), .CNT_W(CNT_W)) u_combiner (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .gen           (gen),
        .counts_a      (counts_a),
        .counts_b      (counts_b),
        .frame_done    (frame_done_a),
        .beat_accept   (beat_accept),
        .beat_last     (S_AXIS_TLAST),
        .M_AXIS_TREADY (M_AXIS_TREADY),
        .in_ready      (S_AXIS_TREADY),
        .M_AXIS_TDATA  (M_AXIS_TDATA),
        .M_AXIS_TVALID (M_AXIS_TVALID),
        .M_AXIS_TLAST  (M_AXIS_TLAST)
    );

endmodule

// File: logic/bundle_combiner.sv
module bundle_combiner #(
    parameter int DIM   = 64,
    parameter int CNT_W = 8
) (
    input  logic                      AXIS_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic                      run,
    input  logic                      gen,
    input  logic [DIM-1:0][CNT_W-1:0] counts_a,
    input  logic [DIM-1:0][CNT_W-1:0] counts_b,
    input  logic                      frame_done,
    input  logic                      beat_accept,
    input  logic                      beat_last,
    input  logic                      M_AXIS_TREADY,
    output logic                      in_ready,
    output logic [DIM-1:0]            M_AXIS_TDATA,
    output logic                      M_AXIS_TVALID,
    output logic                      M_AXIS_TLAST
);

    logic [CNT_W-1:0] beats;
    // frame closed, result not yet taken
    logic             busy;
    logic [DIM-1:0]   sign_vec;
    logic             out_take;

    assign out_take     = M_AXIS_TVALID && M_AXIS_TREADY;
    assign in_ready     = run && !gen && !busy;
    // one beat per frame
    assign M_AXIS_TLAST = M_AXIS_TVALID;

    // majority over two lanes per beat, tie gives 0
    always_comb begin
        for (int d = 0; d < DIM; d++) begin
            sign_vec[d] = ({1'b0, counts_a[d]} + {1'b0, counts_b[d]}) > {1'b0, beats};
        end
    end

    // ----------------------------------------
    // frame and output control
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beats         <= '0;
            busy          <= 1'b0;
            M_AXIS_TVALID <= 1'b0;
        end else begin
            if (out_take) begin
                beats         <= '0;
                busy          <= 1'b0;
                M_AXIS_TVALID <= 1'b0;
            end else if (beat_accept) begin
                beats <= beats + 1'b1;
                if (beat_last) begin
                    busy <= 1'b1;
                end
            end
            if (frame_done) begin
                M_AXIS_TVALID <= 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (frame_done) begin
            M_AXIS_TDATA <= sign_vec;
        end
    end

    a_hold_data : assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID && !M_AXIS_TREADY |=> $stable(M_AXIS_TDATA));

endmodule

// File: logic/hd_encoder_core.sv
module hd_encoder_core #(
    parameter int DIM     = 64,
    parameter int ITEM_AW = 4,
    parameter int CNT_W   = 8
) (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic                        item_wr_en,
    input  logic [ITEM_AW-1:0]          item_wr_addr,
    input  logic [DIM-1:0]              item_wr_data,
    input  logic                        beat_accept,
    input  logic                        beat_last,
    input  logic [hdc_pkg::LANE_W-1:0]  lane,
    output logic [DIM-1:0][CNT_W-1:0]   counts,
    output logic                        frame_done
);

    logic [DIM-1:0] item_mem [2**ITEM_AW];
    logic [DIM-1:0] item_q;
    logic           s1_valid;
    logic           s1_last;
    // next counted beat opens a frame
    logic           fresh;

    // item memory, registered lookup
    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr_en) begin
            item_mem[item_wr_addr] <= item_wr_data;
        end
        item_q <= item_mem[lane[ITEM_AW-1:0]];
    end

    // ----------------------------------------
    // beat pipeline
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            frame_done <= 1'b0;
            fresh      <= 1'b1;
        end else begin
            s1_valid   <= beat_accept;
            s1_last    <= beat_accept && beat_last;
            frame_done <= s1_valid && s1_last;
            if (s1_valid) begin
                fresh <= s1_last;
            end
        end
    end

    // ones per dimension
    always_ff @(posedge AXIS_ACLK) begin
        if (s1_valid) begin
            for (int d = 0; d < DIM; d++) begin
                counts[d] <= (fresh ? '0 : counts[d]) + CNT_W'(item_q[d]);
            end
        end
    end

    a_no_beat_in_wr : assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(beat_accept && item_wr_en));

endmodule

// File: logic/hv_generator.sv
module hv_generator #(
    parameter int DIM     = 64,
    parameter int ITEM_AW = 4
) (
    input  logic               AXIS_ACLK,
    input  logic               S_AXI_ARESETN,
    input  logic               gen,
    input  logic [9:0]         item_count,
    output logic               item_wr_en,
    output logic [ITEM_AW-1:0] item_wr_addr,
    output logic [DIM-1:0]     item_wr_data,
    output logic               gen_done
);
    import hdc_pkg::*;

    // generator words per item
    localparam int WPI  = DIM / RNG_WORD_W;
    localparam int WC_W = (WPI > 1) ? $clog2(WPI) : 1;

    logic [RNG_WORD_W-1:0] rng_q;
    logic [RNG_WORD_W-1:0] rng_a;
    logic [RNG_WORD_W-1:0] rng_b;
    logic [RNG_WORD_W-1:0] rng_next;
    logic [WC_W-1:0]       word_cnt;
    logic [9:0]            issued;
    logic                  active;
    logic                  item_end;

    // xorshift32, shifts 13 17 5
    assign rng_a    = rng_q ^ (rng_q << 13);
    assign rng_b    = rng_a ^ (rng_a >> 17);
    assign rng_next = rng_b ^ (rng_b << 5);

    // still items to make
    assign active   = gen && (issued != item_count);
    assign item_end = active && (word_cnt == WC_W'(WPI - 1));

    // ----------------------------------------
    // sequencing
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        // seed reload whenever idle
        if (!S_AXI_ARESETN || !gen) begin
            rng_q      <= RNG_SEED;
            word_cnt   <= '0;
            issued     <= '0;
            item_wr_en <= 1'b0;
            gen_done   <= 1'b0;
        end else begin
            item_wr_en <= item_end;
            // single pulse once all items are out
            gen_done   <= !gen_done && (issued == item_count);
            if (active) begin
                rng_q    <= rng_next;
                word_cnt <= item_end ? '0 : word_cnt + 1'b1;
            end
            if (item_end) begin
                issued <= issued + 1'b1;
            end
        end
    end

    // shift buffer, first word ends up in the low half
    always_ff @(posedge AXIS_ACLK) begin
        if (active) begin
            item_wr_data <= (item_wr_data >> RNG_WORD_W) |
                            (DIM'(rng_next) << (DIM - RNG_WORD_W));
        end
        if (item_end) begin
            item_wr_addr <= issued[ITEM_AW-1:0];
        end
    end

    a_wr_in_gen : assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_wr_en |-> gen);

endmodule

// File: logic/axil_ctrl_regs.sv
module axil_ctrl_regs (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,

    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] S_AXI_AWADDR,
    input  logic                            S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,

    input  hdc_pkg::ctrl_word_u             S_AXI_WDATA,
    input  logic                            S_AXI_WVALID,
    output logic                            S_AXI_WREADY,

    input  logic                            S_AXI_BREADY,
    output logic [1:0]                      S_AXI_BRESP,
    output logic                            S_AXI_BVALID,

    input  logic [hdc_pkg::AXIL_ADDR_W-1:0] S_AXI_ARADDR,
    input  logic                            S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,

    input  logic                            S_AXI_RREADY,
    output logic [hdc_pkg::AXIL_DATA_W-1:0] S_AXI_RDATA,
    output logic [1:0]                      S_AXI_RRESP,
    output logic                            S_AXI_RVALID,

    input  logic                            gen_done,
    output logic                            gen,
    output logic                            run,
    output logic [9:0]                      item_count
);
    import hdc_pkg::*;

    // handshake states
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_AW   = 3'd1;
    localparam logic [2:0] ST_W    = 3'd2;
    localparam logic [2:0] ST_RESP = 3'd3;
    localparam logic [2:0] ST_AR1  = 3'd4;
    localparam logic [2:0] ST_AR2  = 3'd5;

    logic [2:0]             state;
    logic [AXIL_ADDR_W-1:0] wr_addr;
    ctrl_word_u             wr_word;
    logic [AXIL_ADDR_W-1:0] rd_addr;
    logic                   wr_fire;

    // ----------------------------------------
    // channel handshakes
    // ----------------------------------------
    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_W);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_AW);
    // reads only when no write is pending in idle
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_RESP);
    assign S_AXI_RVALID  = (state == ST_AR2);
    assign S_AXI_BRESP   = RESP_OKAY;
    assign S_AXI_RRESP   = RESP_OKAY;

    // registers take the write once, on the response handshake
    assign wr_fire = S_AXI_BVALID && S_AXI_BREADY;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= ST_RESP;
                    end else if (S_AXI_AWVALID) begin
                        state <= ST_AW;
                    end else if (S_AXI_WVALID) begin
                        state <= ST_W;
                    end else if (S_AXI_ARVALID) begin
                        state <= ST_AR1;
                    end
                end
                // address in, data still due
                ST_AW: if (S_AXI_WVALID) state <= ST_RESP;
                // data in, address still due
                ST_W: if (S_AXI_AWVALID) state <= ST_RESP;
                ST_RESP: if (S_AXI_BREADY) state <= ST_IDLE;
                // one cycle to fetch read data
                ST_AR1: state <= ST_AR2;
                ST_AR2: if (S_AXI_RREADY) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            wr_addr <= S_AXI_AWADDR;
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_word <= S_AXI_WDATA;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            rd_addr <= S_AXI_ARADDR;
        end
    end

    // ----------------------------------------
    // mode and count registers
    // ----------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            run        <= 1'b0;
            item_count <= '0;
        end else if (wr_fire && wr_addr == REG_MODE_ADDR) begin
            gen <= wr_word.mode.gen;
            run <= wr_word.mode.run;
        end else begin
            if (wr_fire && wr_addr == REG_COUNT_ADDR) begin
                item_count <= wr_word.count.item_count;
            end
            // generation finished
            if (gen_done) begin
                gen <= 1'b0;
            end
        end
    end

    // read mux, unmapped reads as zero
    always_ff @(posedge AXIS_ACLK) begin
        if (state == ST_AR1) begin
            case (rd_addr)
                REG_MODE_ADDR:  S_AXI_RDATA <= {{(AXIL_DATA_W-2){1'b0}}, run, gen};
                REG_COUNT_ADDR: S_AXI_RDATA <= {{(AXIL_DATA_W-10){1'b0}}, item_count};
                default:        S_AXI_RDATA <= '0;
            endcase
        end
    end

    a_one_resp : assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(S_AXI_BVALID && S_AXI_RVALID));

endmodule

// File: logic/hdc_pkg.sv
package hdc_pkg;

    // ----------------------------------------
    // control port
    // ----------------------------------------
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    // byte addresses, word aligned
    localparam logic [AXIL_ADDR_W-1:0] REG_MODE_ADDR  = 32'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_COUNT_ADDR = 32'h4;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ----------------------------------------
    // stream lanes and generator
    // ----------------------------------------
    localparam int LANE_W    = 16;
    localparam int NUM_LANES = 2;

    localparam int RNG_WORD_W = 32;
    // xorshift32 start state, must be nonzero
    localparam logic [RNG_WORD_W-1:0] RNG_SEED = 32'd2463534242;

    // top level defaults
    localparam int DEF_DIM     = 64;
    localparam int DEF_ITEM_AW = 4;
    localparam int DEF_CNT_W   = 8;

    // write word seen as mode bits or as item count
    typedef union packed {
        struct packed {
            logic [29:0] rsvd;
            logic        run;
            logic        gen;
        } mode;
        struct packed {
            logic [21:0] rsvd;
            logic [9:0]  item_count;
        } count;
    } ctrl_word_u;

endpackage
